// File: Makefile
# Verilator build and run for the Cholesky factorization testbench

VERILATOR ?= verilator
TOP       ?= cholesky_tb
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

FILELIST := cholesky.f
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: cholesky.f
+incdir+design
design/chol_pkg.sv
design/chol_sqrt.sv
design/chol_div.sv
design/chol_mac.sv
design/chol_tri_store.sv
design/chol_ctrl.sv
design/cholesky.sv
verification/cholesky_tb.sv

// File: design/chol_cfg.svh
`ifndef CHOL_CFG_SVH
`define CHOL_CFG_SVH

// Element format, signed Q16.16
`define CHOL_WORD_BITS 32
`define CHOL_FRAC_BITS 16

// Matrix size and packed lower triangle
`define CHOL_N         3
`define CHOL_TRI_WORDS 6

// Q32.32 accumulator in the multiply-subtract unit
`define CHOL_ACC_BITS  64

`endif

// File: design/chol_ctrl.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module chol_ctrl
    import chol_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     a_valid,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    input  logic     sqrt_done,
    input  word_t    sqrt_root,
    input  logic     div_done,
    input  word_t    div_quot,
    input  word_t    mac_result,
    output logic     load,
    output tri_idx_t rd_idx_a,
    output tri_idx_t rd_idx_b,
    output logic     wr_en,
    output tri_idx_t wr_idx,
    output word_t    wr_data,
    output logic     sqrt_start,
    output word_t    sqrt_operand,
    output logic     div_start,
    output word_t    div_dividend,
    output word_t    div_divisor,
    output logic     mac_load,
    output word_t    mac_init,
    output logic     mac_step,
    output word_t    mac_a,
    output word_t    mac_b,
    output logic     l_valid
);

    localparam logic [1:0] LAST = 2'(`CHOL_N - 1);

    ctrl_state_t state_q;
    logic [1:0]  col_q;  // j
    logic [1:0]  row_q;  // i, equal to j on the diagonal pass
    logic [1:0]  k_q;    // 0 is the load cycle, then k+1 per step
    logic [1:0]  k_prev;
    word_t       dvs_q;  // L(j,j) of the current column
    logic        idle;

    assign idle   = (state_q == st_idle) || (state_q == st_done);
    assign k_prev = (k_q == 2'd0) ? 2'd0 : k_q - 2'd1;

    // --------------------------------------------------
    // Store access
    // --------------------------------------------------
    assign load     = a_valid && idle;
    assign rd_idx_a = tri_index(row_q, (k_q == 2'd0) ? col_q : k_prev);
    assign rd_idx_b = tri_index(col_q, k_prev);

    assign wr_en   = ((state_q == st_sqrt_wait) && sqrt_done) ||
                     ((state_q == st_div_wait) && div_done);
    assign wr_idx  = tri_index(row_q, col_q);
    assign wr_data = (state_q == st_sqrt_wait) ? sqrt_root : div_quot;

    // MAC: A(i,j) on the load cycle, then L(i,k) * L(j,k)
    assign mac_load = (state_q == st_mac_acc) && (k_q == 2'd0);
    assign mac_step = (state_q == st_mac_acc) && (k_q != 2'd0);
    assign mac_init = rd_data_a;
    assign mac_a    = rd_data_a;
    assign mac_b    = rd_data_b;

    // Second drain cycle has the accumulated value
    assign sqrt_start   = (state_q == st_mac_drain) && (k_q == 2'd1) && (row_q == col_q);
    assign div_start    = (state_q == st_mac_drain) && (k_q == 2'd1) && (row_q != col_q);
    assign sqrt_operand = mac_result;
    assign div_dividend = mac_result;
    assign div_divisor  = dvs_q;

    assign l_valid = (state_q == st_done);

    // --------------------------------------------------
    // Column walk
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            col_q   <= 2'd0;
            row_q   <= 2'd0;
            k_q     <= 2'd0;
        end else begin
            case (state_q)
                st_idle, st_done: begin
                    if (a_valid) begin
                        col_q   <= 2'd0;
                        row_q   <= 2'd0;
                        k_q     <= 2'd0;
                        state_q <= st_mac_acc;
                    end
                end
                st_mac_acc: begin
                    if (k_q == col_q) begin  // j products issued
                        k_q     <= 2'd0;
                        state_q <= st_mac_drain;
                    end else begin
                        k_q <= k_q + 2'd1;
                    end
                end
                st_mac_drain: begin
                    if (k_q == 2'd1) begin
                        state_q <= (row_q == col_q) ? st_sqrt_wait : st_div_wait;
                    end else begin
                        k_q <= k_q + 2'd1;
                    end
                end
                st_sqrt_wait: begin
                    if (sqrt_done) begin
                        if (col_q == LAST) begin
                            state_q <= st_done;  // Last diagonal written
                        end else begin
                            row_q   <= col_q + 2'd1;
                            k_q     <= 2'd0;
                            state_q <= st_mac_acc;
                        end
                    end
                end
                st_div_wait: begin
                    if (div_done) begin
                        if (row_q == LAST) begin  // Next column, diagonal first
                            col_q <= col_q + 2'd1;
                            row_q <= col_q + 2'd1;
                        end else begin
                            row_q <= row_q + 2'd1;
                        end
                        k_q     <= 2'd0;
                        state_q <= st_mac_acc;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_sqrt_wait) && sqrt_done) begin
            dvs_q <= sqrt_root;
        end
    end

endmodule

// File: design/chol_div.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module chol_div
    import chol_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output logic  done,
    output word_t quot
);

    localparam int NUM_BITS = `CHOL_WORD_BITS + `CHOL_FRAC_BITS;  // 48 quotient bits
    localparam int W        = `CHOL_WORD_BITS;

    logic [NUM_BITS-1:0] num_q, num_in, num_nx;  // Numerator in, quotient out
    logic [W-1:0]        rem_q, rem_in, rem_nx;
    logic [W-1:0]        dvs_q, dvs_in;
    logic [W:0]          rem_sh, rem_diff;
    logic [W-1:0]        dividend_mag;
    logic [W-1:0]        divisor_mag;
    logic                neg_q;
    logic [5:0]          cnt_q;
    logic                busy_q;
    logic                iter;

    assign dividend_mag = dividend[W-1] ? -dividend : dividend;
    assign divisor_mag  = divisor[W-1] ? -divisor : divisor;

    assign iter = start || (busy_q && (cnt_q != 6'd0));

    // --------------------------------------------------
    // Restoring step on magnitudes
    // --------------------------------------------------
    always_comb begin
        if (start) begin
            num_in = {dividend_mag, {`CHOL_FRAC_BITS{1'b0}}};
            rem_in = '0;
            dvs_in = divisor_mag;
        end else begin
            num_in = num_q;
            rem_in = rem_q;
            dvs_in = dvs_q;
        end
        rem_sh   = {rem_in, num_in[NUM_BITS-1]};
        rem_diff = rem_sh - {1'b0, dvs_in};
        if (rem_sh >= {1'b0, dvs_in}) begin
            rem_nx = rem_diff[W-1:0];
            num_nx = {num_in[NUM_BITS-2:0], 1'b1};
        end else begin
            rem_nx = rem_sh[W-1:0];
            num_nx = {num_in[NUM_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (iter) begin
            num_q <= num_nx;
            rem_q <= rem_nx;
            dvs_q <= dvs_in;
        end
        if (start) begin
            neg_q <= dividend[W-1] ^ divisor[W-1];
        end
        // Sign correction, low word of the quotient
        if (busy_q && (cnt_q == 6'd0)) begin
            quot <= neg_q ? -num_q[W-1:0] : num_q[W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= 6'd0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= 6'(NUM_BITS - 1);
            end else if (busy_q) begin
                if (cnt_q == 6'd0) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 6'd1;
                end
            end
        end
    end

endmodule

// File: design/chol_mac.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module chol_mac
    import chol_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  load,
    input  word_t init,
    input  logic  step,
    input  word_t a,
    input  word_t b,
    output word_t result
);

    logic signed [`CHOL_ACC_BITS-1:0] prod_q;  // Q32.32
    logic                             step_q;
    acc_t                             acc_q;

    // Stage one, product register
    always_ff @(posedge clk) begin
        prod_q <= a * b;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step;
        end
    end

    // Stage two, subtract from the accumulator
    always_ff @(posedge clk) begin
        if (load) begin
            acc_q.fld.guard <= {($bits(acc_q.fld.guard)){init[`CHOL_WORD_BITS-1]}};
            acc_q.fld.mid   <= init;
            acc_q.fld.low   <= '0;
        end else if (step_q) begin
            acc_q.raw <= acc_q.raw - prod_q;
        end
    end

    assign result = acc_q.fld.mid;  // Middle 32 bits, back to Q16.16

endmodule

// File: design/chol_pkg.sv
`include "chol_cfg.svh"

package chol_pkg;

    typedef logic signed [`CHOL_WORD_BITS-1:0] word_t;

    // Q32.32 accumulator, also seen as guard / Q16.16 result / dropped fraction
    typedef union packed {
        logic signed [`CHOL_ACC_BITS-1:0] raw;
        struct packed {
            logic [`CHOL_ACC_BITS-`CHOL_WORD_BITS-`CHOL_FRAC_BITS-1:0] guard;
            word_t                                                     mid;
            logic [`CHOL_FRAC_BITS-1:0]                                low;
        } fld;
    } acc_t;

    typedef logic [2:0] tri_idx_t;

    typedef enum logic [2:0] {
        st_idle,
        st_mac_acc,
        st_mac_drain,
        st_sqrt_wait,
        st_div_wait,
        st_done
    } ctrl_state_t;

    // Element (r,c), c <= r, sits at r(r+1)/2 + c
    function automatic tri_idx_t tri_index(input logic [1:0] r, input logic [1:0] c);
        logic [3:0] tri_base;
        tri_base = {2'b00, r} * ({2'b00, r} + 4'd1);
        return tri_base[3:1] + {1'b0, c};
    endfunction

endpackage

// File: design/chol_sqrt.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module chol_sqrt
    import chol_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t operand,
    output logic  done,
    output word_t root
);

    localparam int RAD_BITS  = `CHOL_WORD_BITS + `CHOL_FRAC_BITS;  // 48
    localparam int ROOT_BITS = RAD_BITS / 2;                        // 24

    logic [RAD_BITS-1:0]  rad_q, rad_in, rad_nx;
    logic [ROOT_BITS+1:0] rem_q, rem_in, rem_nx, trial;
    logic [ROOT_BITS-1:0] rt_q, rt_in, rt_nx;
    logic [4:0]           cnt_q;
    logic                 busy_q;
    logic                 iter;

    // First bit is resolved on the start edge itself
    assign iter = start || (busy_q && (cnt_q != 5'd0));

    // --------------------------------------------------
    // One restoring step per cycle
    // --------------------------------------------------
    always_comb begin
        if (start) begin
            rad_in = {operand, {`CHOL_FRAC_BITS{1'b0}}};  // x * 2^16
            rem_in = '0;
            rt_in  = '0;
        end else begin
            rad_in = rad_q;
            rem_in = rem_q;
            rt_in  = rt_q;
        end
        rem_nx = {rem_in[ROOT_BITS-1:0], rad_in[RAD_BITS-1 -: 2]};
        trial  = {rt_in, 2'b01};
        if (rem_nx >= trial) begin
            rem_nx = rem_nx - trial;
            rt_nx  = {rt_in[ROOT_BITS-2:0], 1'b1};
        end else begin
            rt_nx  = {rt_in[ROOT_BITS-2:0], 1'b0};
        end
        rad_nx = {rad_in[RAD_BITS-3:0], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (iter) begin
            rad_q <= rad_nx;
            rem_q <= rem_nx;
            rt_q  <= rt_nx;
        end
        if (busy_q && (cnt_q == 5'd0)) begin
            root <= {{(`CHOL_WORD_BITS-ROOT_BITS){1'b0}}, rt_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= 5'd0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= 5'(ROOT_BITS - 1);  // Bits left after the start edge
            end else if (busy_q) begin
                if (cnt_q == 5'd0) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 5'd1;
                end
            end
        end
    end

endmodule

// File: design/chol_tri_store.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module chol_tri_store
    import chol_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load,
    input  word_t [`CHOL_TRI_WORDS-1:0] a,
    input  tri_idx_t                    rd_idx_a,
    input  tri_idx_t                    rd_idx_b,
    output word_t                       rd_data_a,
    output word_t                       rd_data_b,
    input  logic                        wr_en,
    input  tri_idx_t                    wr_idx,
    input  word_t                       wr_data,
    output word_t [`CHOL_TRI_WORDS-1:0] l
);

    // A on load, overwritten with L as the factor is produced
    word_t [`CHOL_TRI_WORDS-1:0] mem_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q <= '0;
        end else if (load) begin
            mem_q <= a;
        end else if (wr_en) begin
            mem_q[wr_idx] <= wr_data;
        end
    end

    // Two combinational read ports
    assign rd_data_a = mem_q[rd_idx_a];
    assign rd_data_b = mem_q[rd_idx_b];

    assign l = mem_q;

endmodule

// File: design/cholesky.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module cholesky
    import chol_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  word_t [`CHOL_TRI_WORDS-1:0]  a,
    input  logic                         a_valid,
    output word_t [`CHOL_TRI_WORDS-1:0]  l,
    output logic                         l_valid
);

    logic     load;
    tri_idx_t rd_idx_a;
    tri_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    logic     wr_en;
    tri_idx_t wr_idx;
    word_t    wr_data;

    logic     sqrt_start;
    word_t    sqrt_operand;
    logic     sqrt_done;
    word_t    sqrt_root;

    logic     div_start;
    word_t    div_dividend;
    word_t    div_divisor;
    logic     div_done;
    word_t    div_quot;

    logic     mac_load;
    word_t    mac_init;
    logic     mac_step;
    word_t    mac_a;
    word_t    mac_b;
    word_t    mac_result;

    // --------------------------------------------------
    // Sequencer and matrix storage
    // --------------------------------------------------
    chol_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .a_valid      (a_valid),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .sqrt_done    (sqrt_done),
        .sqrt_root    (sqrt_root),
        .div_done     (div_done),
        .div_quot     (div_quot),
        .mac_result   (mac_result),
        .load         (load),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .sqrt_start   (sqrt_start),
        .sqrt_operand (sqrt_operand),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .mac_load     (mac_load),
        .mac_init     (mac_init),
        .mac_step     (mac_step),
        .mac_a        (mac_a),
        .mac_b        (mac_b),
        .l_valid      (l_valid)
    );

    chol_tri_store u_store (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .a         (a),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .l         (l)
    );

    // --------------------------------------------------
    // Shared arithmetic units
    // --------------------------------------------------
    chol_sqrt u_sqrt (
        .clk     (clk),
        .rst     (rst),
        .start   (sqrt_start),
        .operand (sqrt_operand),
        .done    (sqrt_done),
        .root    (sqrt_root)
    );

    chol_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .done     (div_done),
        .quot     (div_quot)
    );

    chol_mac u_mac (
        .clk    (clk),
        .rst    (rst),
        .load   (mac_load),
        .init   (mac_init),
        .step   (mac_step),
        .a      (mac_a),
        .b      (mac_b),
        .result (mac_result)
    );

endmodule

// File: verification/cholesky_tb.sv
`timescale 1ns/10ps
`include "chol_cfg.svh"

module cholesky_tb
    import chol_pkg::*;
();

    typedef word_t [`CHOL_TRI_WORDS-1:0] tri_t;

    localparam int NUM_MATRICES      = 26;   // 1 + 1 + 1 + 20 + 3
    localparam int CYCLES_PER_MATRIX = 300;

    // Row and column of each packed triangle word
    localparam int ROW_OF [`CHOL_TRI_WORDS] = '{0, 1, 1, 2, 2, 2};
    localparam int COL_OF [`CHOL_TRI_WORDS] = '{0, 0, 1, 0, 1, 2};

    logic        clk;
    logic        rst;
    tri_t        a;
    logic        a_valid;
    tri_t        l;
    logic        l_valid;

    logic [31:0] lfsr_q = 32'he252d181;
    int          err_count = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    cholesky UUT (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_MATRICES * CYCLES_PER_MATRIX) @(posedge clk);
        $display("Timeout: l_valid never rose, controller state is %s",
                 UUT.u_ctrl.state_q.name());
        $display("TEST FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Random numbers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // x^32+x^22+x^2+x+1
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // Diagonal in [1.0, 4.0] and off-diagonal in [-1.0, 1.0]
    function automatic tri_t random_lower();
        tri_t lt;
        for (int w = 0; w < `CHOL_TRI_WORDS; w++) begin
            if (ROW_OF[w] == COL_OF[w]) begin
                lt[w] = 32'sh10000 + word_t'(rand_bits(18) % 32'h30001);
            end else begin
                lt[w] = word_t'(rand_bits(18) % 32'h20001) - 32'sh10000;
            end
        end
        return lt;
    endfunction

    // A = L * L^T truncated back to Q16.16
    function automatic tri_t make_spd(input tri_t lt);
        tri_t   am;
        longint s;
        int     r;
        int     c;
        for (int w = 0; w < `CHOL_TRI_WORDS; w++) begin
            r = ROW_OF[w];
            c = COL_OF[w];
            s = 0;
            for (int k = 0; k <= c; k++) begin
                s = s + longint'(lt[r * (r + 1) / 2 + k]) * longint'(lt[c * (c + 1) / 2 + k]);
            end
            am[w] = s[47:16];
        end
        return am;
    endfunction

    function automatic longint isqrt(input longint x);
        longint r;
        longint t;
        r = 0;
        for (int b = 23; b >= 0; b--) begin
            t = r | (longint'(1) << b);
            if (t * t <= x) begin
                r = t;
            end
        end
        return r;
    endfunction

    function automatic tri_t ref_factor(input tri_t am);
        longint m [`CHOL_N][`CHOL_N];
        longint f [`CHOL_N][`CHOL_N];
        longint acc;
        longint mid;
        longint quo;
        tri_t   res;
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c < `CHOL_N; c++) begin
                m[r][c] = 0;
                f[r][c] = 0;
            end
        end
        for (int w = 0; w < `CHOL_TRI_WORDS; w++) begin
            m[ROW_OF[w]][COL_OF[w]] = longint'(am[w]);
        end
        for (int j = 0; j < `CHOL_N; j++) begin
            for (int i = j; i < `CHOL_N; i++) begin
                acc = m[i][j] <<< 16;  // Q32.32
                for (int k = 0; k < j; k++) begin
                    acc = acc - f[i][k] * f[j][k];
                end
                mid = longint'($signed(acc[47:16]));
                if (i == j) begin
                    f[j][j] = isqrt(longint'(mid[31:0]) << 16);
                end else begin
                    quo     = (mid <<< 16) / f[j][j];  // Truncates toward zero
                    f[i][j] = longint'($signed(quo[31:0]));
                end
            end
        end
        for (int w = 0; w < `CHOL_TRI_WORDS; w++) begin
            res[w] = f[ROW_OF[w]][COL_OF[w]][31:0];
        end
        return res;
    endfunction

    // --------------------------------------------------
    // Driving, checking and reporting
    // --------------------------------------------------
    task automatic send_matrix(input tri_t am);
        @(posedge clk);
        a       <= am;
        a_valid <= 1'b1;
        @(posedge clk);  // Sampled here
        a_valid <= 1'b0;
    endtask

    task automatic wait_result();
        @(negedge clk);
        while (!l_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_result(input string name, input tri_t expected);
        for (int w = 0; w < `CHOL_TRI_WORDS; w++) begin
            check_word($sformatf("%s l[%0d]", name, w), expected[w], l[w]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_check();
        int   errs;
        tri_t am;
        errs  = err_count;
        am    = '0;
        am[0] = 32'sh10000;
        am[2] = 32'sh10000;
        am[5] = 32'sh10000;
        @(negedge clk);
        check_flag("reset l_valid", 1'b0, l_valid);
        send_matrix(am);
        @(negedge clk);
        check_flag("reset accepted", 1'b0, l_valid);
        wait_result();
        repeat (4) @(negedge clk);
        check_flag("reset held", 1'b1, l_valid);  // Stays up with no new strobe
        compare_result("reset", am);  // Identity is its own factor
        report_test("reset", errs);
    endtask

    task automatic diagonal_matrix();
        int   errs;
        tri_t am;
        tri_t ex;
        errs  = err_count;
        am    = '0;
        ex    = '0;
        am[0] = 32'sh40000;   // 4.0
        am[2] = 32'sh90000;   // 9.0
        am[5] = 32'sh24000;   // 2.25
        ex[0] = 32'sh20000;
        ex[2] = 32'sh30000;
        ex[5] = 32'sh18000;
        send_matrix(am);
        wait_result();
        compare_result("diagonal", ex);
        report_test("diagonal", errs);
    endtask

    task automatic integer_factor();
        int   errs;
        tri_t lt;
        errs  = err_count;
        lt[0] = 32'sh20000;
        lt[1] = 32'sh10000;
        lt[2] = 32'sh30000;
        lt[3] = -32'sh10000;  // Negative element
        lt[4] = 32'sh20000;
        lt[5] = 32'sh40000;
        send_matrix(make_spd(lt));
        wait_result();
        compare_result("integer factor", lt);
        report_test("integer factor", errs);
    endtask

    task automatic random_matrices();
        int   errs;
        tri_t am;
        errs = err_count;
        for (int n = 0; n < 20; n++) begin
            am = make_spd(random_lower());
            send_matrix(am);
            wait_result();
            compare_result($sformatf("random %0d", n), ref_factor(am));
        end
        report_test("random", errs);
    endtask

    task automatic busy_and_back_to_back();
        int   errs;
        tri_t m1;
        tri_t m2;
        tri_t m3;
        errs = err_count;
        m1   = make_spd(random_lower());
        m2   = make_spd(random_lower());
        m3   = make_spd(random_lower());
        send_matrix(m1);
        repeat (5) @(posedge clk);
        send_matrix(m2);  // Arrives mid-run
        @(negedge clk);
        check_flag("busy l_valid", 1'b0, l_valid);
        wait_result();
        compare_result("busy", ref_factor(m1));
        send_matrix(m3);
        @(negedge clk);
        check_flag("back-to-back l_valid", 1'b0, l_valid);
        wait_result();
        compare_result("back-to-back", ref_factor(m3));
        report_test("busy and back-to-back", errs);
    endtask

    initial begin
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        reset_check();
        diagonal_matrix();
        integer_factor();
        random_matrices();
        busy_and_back_to_back();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
